// ==== sim.f ====
+incdir+hw
hw/tftPkg.sv
hw/tftFillEngine.sv
hw/tftInitSequencer.sv
hw/tftBusTiming.sv
hw/tftController.sv
test/tftBusModel.sv
test/tftControllerTb.sv

// ==== test/tftControllerTb.sv ====
`timescale 1ns/100ps

module tftControllerTb
    import tftPkg::*;
();

    localparam int WrLow       = 2;
    localparam int WrHigh      = 1;
    localparam int RstLow      = 20;
    localparam int RstWait     = 10;
    localparam int ResetCycles = 8;
    // Worst case of the table, two 3x2 fills and five 8x8 fills.
    localparam int MaxWords    = 7 + 2 * (7 + 6) + 5 * (7 + 64);
    localparam int CycleLimit  = ResetCycles + RstLow + 2 * RstWait
                               + MaxWords * (WrLow + WrHigh + 2) + 200;
    localparam tftPins_t ResetPins = '{rst: 1'b1, cs: 1'b1, rs: 1'b1, wr: 1'b1,
                                       rd: 1'b1, blCtl: 1'b0, data: 16'h0000};

    typedef tftWord_t wordQ_t [$];

    logic     clk;
    logic     rst_n;
    logic     fillStart;
    tftFill_t fillReq;
    logic     fillBusy;
    logic     initDone;
    tftPins_t lcd;
    tftWord_t capWord;
    logic     capValid;

    wordQ_t   expQ;               // Words still to come.
    string    expTest [$];        // Owning test of each expected word.
    string    curTest;
    int       testErrs [string];
    int       errCount;
    int       testCount;
    int       failCount;
    int       cycles;
    int       seed = 31187;
    wordQ_t   q;
    tftFill_t fill;
    int       pixels;
    int       wordsBefore;

    tftController #(
        .WrLowCycles   (WrLow),
        .WrHighCycles  (WrHigh),
        .RstLowCycles  (RstLow),
        .RstWaitCycles (RstWait)
    ) i_tftController
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .fillStart (fillStart),
        .fillReq   (fillReq),
        .fillBusy  (fillBusy),
        .initDone  (initDone),
        .lcd       (lcd)
    );

    tftBusModel i_busModel (.clk(clk), .rst_n(rst_n), .lcd(lcd),
                            .capWord(capWord), .capValid(capValid));

    always #5 clk = ~clk;   // 100 MHz.

    ////////////////////
    // Reference model.
    ////////////////////

    // Header of seven words, then one color word per point.
    function automatic wordQ_t fillWords(tftFill_t f);
        wordQ_t r;
        int     n;
        r = {};
        if (f.x1 < f.x0 || f.y1 < f.y0)
            return r;                       // Inverted window sends nothing.
        r.push_back('{kind: Cmd,  payload: CmdColAddr});
        r.push_back('{kind: Data, payload: {6'd0, f.x0}});
        r.push_back('{kind: Data, payload: {6'd0, f.x1}});
        r.push_back('{kind: Cmd,  payload: CmdRowAddr});
        r.push_back('{kind: Data, payload: {6'd0, f.y0}});
        r.push_back('{kind: Data, payload: {6'd0, f.y1}});
        r.push_back('{kind: Cmd,  payload: CmdMemWrite});
        n = (int'(f.x1) - int'(f.x0) + 1) * (int'(f.y1) - int'(f.y0) + 1);
        for (int i = 0; i < n; i++)
            r.push_back('{kind: Data, payload: f.color});
        return r;
    endfunction

    // Ordered corners with sides 1 to 8.
    function automatic tftFill_t randomFill();
        tftFill_t f;
        f.x0    = 10'($random(seed) & 32'h1FF);
        f.x1    = f.x0 + 10'($random(seed) & 32'h7);
        f.y0    = 10'($random(seed) & 32'h0FF);
        f.y1    = f.y0 + 10'($random(seed) & 32'h7);
        f.color = 16'($random(seed));
        return f;
    endfunction

    ////////////////////
    // Checks.
    ////////////////////

    task automatic countError(string name);
        testErrs[name] = testErrs[name] + 1;
        errCount = errCount + 1;
    endtask

    task automatic checkWord(string name, tftWord_t exp, tftWord_t act);
        if (act !== exp)
        begin
            $display("Fail %s: expected %s %h, actual %s %h", name, exp.kind.name(),
                     exp.payload, act.kind.name(), act.payload);
            countError(name);
        end
    endtask

    task automatic checkCount(string name, string what, int exp, int act, bit atLeast = 1'b0);
        if (atLeast ? (act < exp) : (act != exp))
        begin
            $display("Fail %s %s: expected %s%0d, actual %0d", name, what,
                     atLeast ? "at least " : "", exp, act);
            countError(name);
        end
    endtask

    task automatic checkPins(string name, tftPins_t exp, tftPins_t act);
        if (act !== exp)
        begin
            $display("Fail %s pins: expected %h, actual %h", name, exp, act);
            countError(name);
        end
    endtask

    // Each captured word against the head of the expected queue.
    always @(posedge clk)
    begin
        if (capValid === 1'b1)
        begin
            if (expQ.size() == 0)
            begin
                $display("Bus write %h arrived with no word expected in %s", capWord, curTest);
                countError(curTest);
            end
            else
                checkWord(expTest.pop_front(), expQ.pop_front(), capWord);
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == CycleLimit)
        begin
            $display("Run stopped by timeout after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // Test flow.
    ////////////////////

    task automatic beginTest(string name);
        curTest = name;
        testErrs[name] = 0;
    endtask

    task automatic endTest(string name);
        testCount = testCount + 1;
        if (testErrs[name] == 0)
            $display("Test %s: ok", name);
        else
        begin
            failCount = failCount + 1;
            $display("Test %s: %0d errors", name, testErrs[name]);
        end
    endtask

    task automatic expectWords(string name, wordQ_t w);
        foreach (w[i])
        begin
            expQ.push_back(w[i]);
            expTest.push_back(name);
        end
    endtask

    // Called 1 ns after an edge; returns the same way.
    task automatic startFill(tftFill_t f);
        while (fillBusy)
        begin
            @(posedge clk);
            #1;
        end
        fillReq   = f;
        fillStart = 1'b1;
        @(posedge clk);
        #1;
        fillStart = 1'b0;
    endtask

    // Four quiet cycles with the chip deselected.
    task automatic waitIdle();
        int quiet;
        quiet = 0;
        while (quiet < 4)
        begin
            @(posedge clk);
            #1;
            quiet = (!fillBusy && lcd.cs) ? quiet + 1 : 0;
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        fillStart = 1'b0;
        fillReq   = '0;

        beginTest("reset");
        repeat (ResetCycles / 2) @(posedge clk);
        #1;
        checkPins("reset", ResetPins, lcd);
        checkCount("reset", "initDone", 0, initDone);
        checkCount("reset", "fillBusy", 0, fillBusy);
        repeat (ResetCycles - ResetCycles / 2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        endTest("reset");

        // Fill queued behind the bring-up table.
        beginTest("earlyFill");
        beginTest("bringUp");
        q = {};
        q.push_back('{kind: Cmd,  payload: 16'h0011});
        q.push_back('{kind: Cmd,  payload: 16'h003A});
        q.push_back('{kind: Data, payload: 16'h0055});
        q.push_back('{kind: Cmd,  payload: 16'h0029});
        expectWords("bringUp", q);
        fill = '{x0: 10'd5, x1: 10'd7, y0: 10'd10, y1: 10'd11, color: 16'hF800};
        expectWords("earlyFill", fillWords(fill));
        startFill(fill);
        waitIdle();
        checkCount("bringUp", "rst low cycles", RstLow, i_busModel.rstWidth, 1'b1);
        checkCount("bringUp", "words before backlight", 4, i_busModel.blWords);
        checkCount("bringUp", "initDone", 1, initDone);
        endTest("bringUp");
        checkCount("earlyFill", "words missing", 0, expQ.size());
        endTest("earlyFill");

        beginTest("singleFill");
        fill = '{x0: 10'd100, x1: 10'd102, y0: 10'd50, y1: 10'd51, color: 16'h07E0};
        expectWords("singleFill", fillWords(fill));
        startFill(fill);
        waitIdle();
        checkCount("singleFill", "words missing", 0, expQ.size());
        endTest("singleFill");

        // Each fill starts back to back once fillBusy drops.
        beginTest("randomFills");
        pixels      = 0;
        wordsBefore = i_busModel.words.size();
        repeat (5)
        begin
            fill   = randomFill();
            pixels = pixels + (int'(fill.x1) - int'(fill.x0) + 1)
                            * (int'(fill.y1) - int'(fill.y0) + 1);
            expectWords("randomFills", fillWords(fill));
            startFill(fill);
        end
        waitIdle();
        checkCount("randomFills", "pixel words", pixels,
                   i_busModel.words.size() - wordsBefore - 5 * 7);
        checkCount("randomFills", "words missing", 0, expQ.size());
        endTest("randomFills");

        beginTest("ignored");
        wordsBefore = i_busModel.words.size();
        fill = '{x0: 10'd20, x1: 10'd10, y0: 10'd3, y1: 10'd4, color: 16'hFFFF};
        startFill(fill);
        checkCount("ignored", "fillBusy", 0, fillBusy);
        waitIdle();
        checkCount("ignored", "words written", 0, i_busModel.words.size() - wordsBefore);
        endTest("ignored");

        // Widths gathered over the whole run.
        beginTest("writeTiming");
        checkCount("writeTiming", "shortest wr low", WrLow, i_busModel.minLow);
        checkCount("writeTiming", "longest wr low", WrLow, i_busModel.maxLow);
        checkCount("writeTiming", "shortest wr high", WrHigh, i_busModel.minHigh);
        checkCount("writeTiming", "wr low with cs high", 0, i_busModel.csBad);
        checkCount("writeTiming", "rd low", 0, i_busModel.rdBad);
        endTest("writeTiming");

        $display("%0d tests run, %0d with errors, %0d errors", testCount, failCount, errCount);
        if (errCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== test/tftBusModel.sv ====
`timescale 1ns/100ps

module tftBusModel
    import tftPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  tftPins_t lcd,
    output tftWord_t capWord,     // Last word latched by the panel.
    output logic     capValid     // High for one cycle per latched word.
);

    tftWord_t words [$];          // Every latched word, in order.
    tftPins_t prev;
    int       cycle;
    int       lowRun;
    int       highRun;            // Zero until the first rising WR.
    int       minLow  = 1 << 30;
    int       maxLow;
    int       minHigh = 1 << 30;
    int       csBad;              // WR low with chip deselected.
    int       rdBad;
    int       rstFall;
    int       rstWidth;
    int       blWords = -1;       // Words seen when backlight came on.

    ////////////////////
    // Pin sampling.
    ////////////////////

    // Mid-cycle, away from the DUT edges.
    always @(negedge clk)
    begin
        cycle    = cycle + 1;
        capValid = 1'b0;
        if (rst_n)
        begin
            if (!lcd.wr && lcd.cs)
                csBad = csBad + 1;
            if (!lcd.rd)
                rdBad = rdBad + 1;
            if (lcd.wr && !prev.wr)
            begin
                // Panel latch point.
                capWord  = '{kind: lcd.rs ? Data : Cmd, payload: lcd.data};
                capValid = 1'b1;
                words.push_back(capWord);
                minLow  = (lowRun < minLow) ? lowRun : minLow;
                maxLow  = (lowRun > maxLow) ? lowRun : maxLow;
                highRun = 1;
            end
            else if (!lcd.wr && prev.wr)
            begin
                if (highRun > 0 && highRun < minHigh)
                    minHigh = highRun;      // High phase between two words.
                lowRun = 1;
            end
            else if (!lcd.wr)
                lowRun = lowRun + 1;
            else if (highRun > 0)
                highRun = highRun + 1;
            if (!lcd.rst && prev.rst)
                rstFall = cycle;            // Panel reset pulse starts.
            if (lcd.rst && !prev.rst)
                rstWidth = cycle - rstFall;
            if (lcd.blCtl && !prev.blCtl)
                blWords = words.size();
        end
        prev = lcd;
    end

endmodule

// ==== hw/tftController.sv ====
`timescale 1ns/100ps

module tftController
    import tftPkg::*;
#(
    // Defaults for a 50 MHz clock.
    parameter int WrLowCycles   = 2,
    parameter int WrHighCycles  = 2,
    parameter int RstLowCycles  = 500_000,     // 10 ms reset pulse.
    parameter int RstWaitCycles = 6_000_000    // 120 ms recovery.
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fillStart,
    input  tftFill_t fillReq,
    output logic     fillBusy,
    output logic     initDone,
    output tftPins_t lcd
);

    // Fill engine to sequencer.
    tftWord_t fillWord;
    logic     fillStb;
    logic     seqBusy;

    // Sequencer to bus timing.
    tftWord_t word;
    logic     wordStb;
    logic     busBusy;

    ////////////////////
    // Stage chain.
    ////////////////////

    tftFillEngine i_fillEngine
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .fillStart (fillStart),
        .fillReq   (fillReq),
        .fillBusy  (fillBusy),
        .fillWord  (fillWord),
        .fillStb   (fillStb),
        .seqBusy   (seqBusy)
    );

    tftInitSequencer #(
        .RstLowCycles  (RstLowCycles),
        .RstWaitCycles (RstWaitCycles)
    ) i_initSequencer
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .fillWord (fillWord),
        .fillStb  (fillStb),
        .seqBusy  (seqBusy),
        .word     (word),
        .wordStb  (wordStb),
        .busBusy  (busBusy),
        .initDone (initDone)
    );

    tftBusTiming #(
        .WrLowCycles  (WrLowCycles),
        .WrHighCycles (WrHighCycles)
    ) i_busTiming
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .word    (word),
        .wordStb (wordStb),
        .busBusy (busBusy),
        .lcd     (lcd)
    );

endmodule

// ==== hw/tftBusTiming.sv ====
`timescale 1ns/100ps

module tftBusTiming
    import tftPkg::*;
#(
    parameter int WrLowCycles  = 2,
    parameter int WrHighCycles = 2
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  tftWord_t word,
    input  logic     wordStb,
    output logic     busBusy,
    output tftPins_t lcd
);

    localparam int PhaseMax = (WrLowCycles > WrHighCycles) ? WrLowCycles : WrHighCycles;
    localparam int PhaseW   = $clog2(PhaseMax + 1);

    logic [PhaseW-1:0] phaseCnt;   // Cycles left in the WR phase.
    logic              writing;    // Write cycle in progress.
    logic              lowPhase;   // WR low part.

    ////////////////////
    // Write cycle.
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lcd      <= '{rst: 1'b1, cs: 1'b1, rs: 1'b1, wr: 1'b1, rd: 1'b1,
                          blCtl: 1'b0, data: 16'd0};
            busBusy  <= 1'b0;
            phaseCnt <= '0;
            writing  <= 1'b0;
            lowPhase <= 1'b0;
        end
        else if (wordStb)
        begin
            busBusy <= 1'b1;
            case (word.kind)
                Cmd, Data:
                begin
                    lcd.cs   <= 1'b0;
                    lcd.rs   <= (word.kind == Data);   // Cmd 0, data 1.
                    lcd.data <= word.payload;
                    lcd.wr   <= 1'b0;
                    writing  <= 1'b1;
                    lowPhase <= 1'b1;
                    phaseCnt <= PhaseW'(WrLowCycles - 1);
                end
                PinReset:
                begin
                    lcd.rst <= word.payload[0];
                    writing <= 1'b0;
                end
                default:
                begin
                    lcd.blCtl <= word.payload[0];   // Backlight.
                    writing   <= 1'b0;
                end
            endcase
        end
        else if (writing)
        begin
            if (lowPhase)
            begin
                if (phaseCnt == '0)
                begin
                    lcd.wr   <= 1'b1;               // Panel latches here.
                    lowPhase <= 1'b0;
                    phaseCnt <= PhaseW'(WrHighCycles - 1);
                    busBusy  <= (WrHighCycles > 1); // Free in last high cycle.
                end
                else
                    phaseCnt <= phaseCnt - 1'b1;
            end
            else
            begin
                if (phaseCnt == '0)
                    writing <= 1'b0;                // cs held one more cycle.
                else
                begin
                    phaseCnt <= phaseCnt - 1'b1;
                    if (phaseCnt == PhaseW'(1))
                        busBusy <= 1'b0;
                end
            end
        end
        else
        begin
            busBusy <= 1'b0;    // Pin word done.
            lcd.cs  <= 1'b1;    // Idle cycle ends the burst.
        end
    end

    ////////////////////
    // Bus checks.
    ////////////////////

    // Strobe only with the chip selected.
    assert property (@(posedge clk) disable iff (!rst_n) !lcd.wr |-> !lcd.cs);

    // Panel is never read.
    assert property (@(posedge clk) disable iff (!rst_n) lcd.rd);

endmodule

// ==== hw/tftInitSequencer.sv ====
`timescale 1ns/100ps

module tftInitSequencer
    import tftPkg::*;
#(
    parameter int RstLowCycles  = 500_000,
    parameter int RstWaitCycles = 6_000_000
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  tftWord_t fillWord,
    input  logic     fillStb,
    output logic     seqBusy,
    output tftWord_t word,
    output logic     wordStb,
    input  logic     busBusy,
    output logic     initDone
);

    `include "tftInitTable.svh"

    localparam int DelayMax = (RstLowCycles > RstWaitCycles) ? RstLowCycles : RstWaitCycles;
    localparam int DelayW   = $clog2(DelayMax + 1);

    tftWord_t          outWord;     // One-word holding register.
    logic              outValid;
    logic [2:0]        idx;         // Table position.
    logic [DelayW-1:0] delayCnt;
    logic              waiting;
    logic              loadEntry;

    assign loadEntry = !initDone && !waiting && !outValid;
    assign word      = outWord;
    assign wordStb   = outValid && !busBusy;
    assign seqBusy   = outValid || !initDone;   // Fills blocked during bring-up.

    ////////////////////
    // Table walk.
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            outValid <= 1'b0;
            idx      <= 3'd0;
            delayCnt <= '0;
            waiting  <= 1'b0;
            initDone <= 1'b0;
        end
        else
        begin
            if (wordStb)
                outValid <= 1'b0;       // Bus took the word.
            if (!initDone)
            begin
                if (wordStb)
                begin
                    idx <= idx + 3'd1;
                    if (idx == 3'(InitLen - 1))
                        initDone <= 1'b1;   // Backlight accepted.
                    case (InitWait[idx])
                        WaitLow:
                        begin
                            waiting  <= 1'b1;
                            delayCnt <= DelayW'(RstLowCycles - 1);
                        end
                        WaitLong:
                        begin
                            waiting  <= 1'b1;
                            delayCnt <= DelayW'(RstWaitCycles - 1);
                        end
                        default: waiting <= 1'b0;
                    endcase
                end
                else if (waiting)
                begin
                    if (delayCnt == '0)
                        waiting <= 1'b0;
                    else
                        delayCnt <= delayCnt - 1'b1;
                end
                else if (loadEntry)
                    outValid <= 1'b1;   // Next table entry.
            end
            else if (fillStb)
                outValid <= 1'b1;       // Pass-through.
        end
    end

    // Payload register.
    always_ff @(posedge clk)
    begin
        if (loadEntry)
            outWord <= InitTable[idx];
        else if (fillStb)
            outWord <= fillWord;
    end

    // Bus goes busy right after it takes a word.
    assert property (@(posedge clk) disable iff (!rst_n) wordStb |=> busBusy);

endmodule

// ==== hw/tftFillEngine.sv ====
`timescale 1ns/100ps

module tftFillEngine
    import tftPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fillStart,
    input  tftFill_t fillReq,
    output logic     fillBusy,
    output tftWord_t fillWord,
    output logic     fillStb,
    input  logic     seqBusy
);

    tftFill_t   req;        // Request held for the whole fill.
    tftWord_t   outWord;    // Output register.
    tftWord_t   nextWord;
    logic       outValid;
    logic       active;     // Words still to generate.
    logic       inPixels;   // Header done.
    logic [2:0] hdrIdx;
    logic [9:0] col;
    logic [9:0] row;
    logic       reqOk;
    logic       start;
    logic       advance;

    assign reqOk    = (fillReq.x1 >= fillReq.x0) && (fillReq.y1 >= fillReq.y0);
    assign start    = fillStart && !fillBusy;
    assign advance  = active && (!outValid || fillStb);   // Register free or emptying.
    assign fillBusy = active || outValid;                 // Until last pixel handed over.
    assign fillStb  = outValid && !seqBusy;
    assign fillWord = outWord;

    // Header word or pixel for the current step.
    always_comb
    begin
        nextWord = '{kind: Data, payload: req.color};
        if (!inPixels)
        begin
            case (hdrIdx)
                3'd0: nextWord = '{kind: Cmd, payload: CmdColAddr};
                3'd1: nextWord = '{kind: Data, payload: {6'd0, req.x0}};
                3'd2: nextWord = '{kind: Data, payload: {6'd0, req.x1}};
                3'd3: nextWord = '{kind: Cmd, payload: CmdRowAddr};
                3'd4: nextWord = '{kind: Data, payload: {6'd0, req.y0}};
                3'd5: nextWord = '{kind: Data, payload: {6'd0, req.y1}};
                default: nextWord = '{kind: Cmd, payload: CmdMemWrite};
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active   <= 1'b0;
            outValid <= 1'b0;
            inPixels <= 1'b0;
            hdrIdx   <= 3'd0;
            col      <= 10'd0;
            row      <= 10'd0;
        end
        else if (start)
        begin
            active   <= reqOk;          // Inverted corners are dropped.
            inPixels <= 1'b0;
            hdrIdx   <= 3'd0;
            col      <= fillReq.x0;
            row      <= fillReq.y0;
        end
        else if (advance)
        begin
            outValid <= 1'b1;
            if (!inPixels)
            begin
                hdrIdx <= hdrIdx + 3'd1;
                if (hdrIdx == 3'd6)
                    inPixels <= 1'b1;   // Memory write sent.
            end
            else if (col == req.x1)
            begin
                col <= req.x0;          // Next row.
                if (row == req.y1)
                    active <= 1'b0;     // Last pixel.
                else
                    row <= row + 10'd1;
            end
            else
                col <= col + 10'd1;
        end
        else if (fillStb)
            outValid <= 1'b0;
    end

    // Payload registers.
    always_ff @(posedge clk)
    begin
        if (start)
            req <= fillReq;
        if (advance)
            outWord <= nextWord;
    end

    // Outside must wait for the previous fill.
    assert property (@(posedge clk) disable iff (!rst_n) fillBusy |-> !fillStart);

endmodule

// ==== hw/tftPkg.sv ====
package tftPkg;

    ////////////////////
    // Word stream types.
    ////////////////////

    // Meaning of one word in the stream.
    typedef enum logic [1:0]
    {
        Cmd       = 2'd0,   // Command byte, RS low.
        Data      = 2'd1,   // Parameter or pixel, RS high.
        PinReset  = 2'd2,   // Payload bit 0 sets panel reset.
        Backlight = 2'd3    // Payload bit 0 sets backlight.
    } tftKind_e;

    // One word between the stages.
    typedef struct packed
    {
        tftKind_e    kind;
        logic [15:0] payload;
    } tftWord_t;

    // Physical panel pins.
    typedef struct packed
    {
        logic        rst;     // Active low.
        logic        cs;      // Active low.
        logic        rs;      // Cmd 0, data 1.
        logic        wr;      // Panel latches on rising edge.
        logic        rd;      // Never used, held high.
        logic        blCtl;   // Backlight enable.
        logic [15:0] data;
    } tftPins_t;

    // Rectangle fill request, corners inclusive.
    typedef struct packed
    {
        logic [9:0]  x0;
        logic [9:0]  x1;
        logic [9:0]  y0;
        logic [9:0]  y1;
        logic [15:0] color;   // RGB565.
    } tftFill_t;

    // Controller commands used by a fill.
    localparam logic [15:0] CmdColAddr  = 16'h002A;
    localparam logic [15:0] CmdRowAddr  = 16'h002B;
    localparam logic [15:0] CmdMemWrite = 16'h002C;

endpackage

// ==== hw/tftInitTable.svh ====
`ifndef TFT_INIT_TABLE_SVH
`define TFT_INIT_TABLE_SVH

////////////////////
// Bring-up list.
////////////////////

// Number of entries in the list.
localparam int InitLen = 7;

// Delay that follows an entry once the bus has taken it.
localparam logic [1:0] WaitNone = 2'd0;
localparam logic [1:0] WaitLow  = 2'd1;   // Reset pulse width.
localparam logic [1:0] WaitLong = 2'd2;   // Recovery after reset or sleep out.

// Words sent in order.
localparam tftWord_t InitTable [InitLen] = '{
    '{kind: PinReset,  payload: 16'h0000},   // Reset low.
    '{kind: PinReset,  payload: 16'h0001},   // Reset released.
    '{kind: Cmd,       payload: 16'h0011},   // Sleep out.
    '{kind: Cmd,       payload: 16'h003A},   // Pixel format.
    '{kind: Data,      payload: 16'h0055},   // 16 bits per pixel.
    '{kind: Cmd,       payload: 16'h0029},   // Display on.
    '{kind: Backlight, payload: 16'h0001}    // Backlight on.
};

// Delay after each entry, same order.
localparam logic [1:0] InitWait [InitLen] = '{
    WaitLow, WaitLong, WaitLong, WaitNone, WaitNone, WaitNone, WaitNone
};

`endif
